// File: rv_core.f
logic/rv_core_pkg.sv
logic/instr_decoder.sv
logic/integer_alu.sv
logic/writeback_regfile.sv
logic/cycle_sequencer.sv
logic/rv_core_top.sv
testbench/clock_gen.sv
testbench/rv_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -f sim.log

verilator --binary --timing -j 0 --top-module rv_core_tb -f rv_core.f -o rv_core_sim

# the simulator exit status is not trusted alone, the log decides
./obj_dir/rv_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench passed" sim.log; then
	echo "simulation PASS"
	exit 0
else
	echo "simulation FAIL"
	exit 1
fi

// File: testbench/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb import rv_core_pkg::*; ();

	localparam int retire_timeout = 20;
	localparam int fetch_timeout = 20;

	logic clk, rst;
	logic imem_req, dmem_req, dmem_we, retire_valid, retire_we;
	word_t imem_addr, imem_rdata, dmem_addr, dmem_wdata, dmem_rdata;
	word_t retire_pc, retire_wdata;
	reg_idx_t retire_rd;

	word_t imem [256];
	word_t dmem [256];
	int prog_len;
	int seed;
	int cycle_count;

	// reference model state
	word_t m_regs [32];
	word_t m_dmem [256];
	word_t m_pc, m_next;
	word_t exp_pc, exp_wdata, exp_daddr, exp_dwdata;
	reg_idx_t exp_rd;
	logic exp_we, exp_dreq, exp_dwe;

	// observed data requests
	word_t dm_addr [$];
	word_t dm_wdata [$];
	logic dm_we [$];

	clock_gen clk_i (.clk(clk), .rst(rst));

	rv_core_top dut_i (
		.clk(clk),
		.rst(rst),
		.imem_req(imem_req),
		.imem_addr(imem_addr),
		.imem_rdata(imem_rdata),
		.dmem_req(dmem_req),
		.dmem_we(dmem_we),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_rdata(dmem_rdata),
		.retire_valid(retire_valid),
		.retire_pc(retire_pc),
		.retire_rd(retire_rd),
		.retire_we(retire_we),
		.retire_wdata(retire_wdata)
	);

	task automatic fail_now();
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic fail_msg(input string what);
		$display("%0t: %s", $time, what);
		fail_now();
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
			fail_now();
		end
	endtask

	task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
			fail_now();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
			fail_now();
		end
	endtask

	// instruction memory with a one cycle read latency
	always @(posedge clk) begin
		if (imem_req)
			imem_rdata <= imem[imem_addr[9:2]];
	end

	// data memory
	always @(posedge clk) begin
		if (dmem_req) begin
			if (dmem_we)
				dmem[dmem_addr[9:2]] <= dmem_wdata;
			else
				dmem_rdata <= dmem[dmem_addr[9:2]];
		end
	end

	always @(posedge clk) cycle_count <= cycle_count + 1;

	always @(negedge clk) begin
		if (rst && (imem_req || dmem_req || dmem_we || retire_valid))
			fail_msg("a request or retire strobe was active during reset");
		if (!rst && dmem_req) begin
			dm_addr.push_back(dmem_addr);
			dm_wdata.push_back(dmem_wdata);
			dm_we.push_back(dmem_we);
		end
	end

	function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
			input reg_idx_t rs1, input logic [2:0] f3, input reg_idx_t rd);
		return {f7, rs2, rs1, f3, rd, opc_op};
	endfunction

	function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
			input logic [2:0] f3, input reg_idx_t rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic word_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
			input reg_idx_t rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
	endfunction

	function automatic word_t enc_b(input logic [12:0] imm, input reg_idx_t rs2,
			input reg_idx_t rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
	endfunction

	function automatic word_t enc_u(input logic [19:0] imm, input reg_idx_t rd,
			input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic word_t enc_j(input logic [20:0] imm, input reg_idx_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
	endfunction

	task automatic emit(input word_t w);
		imem[prog_len] = w;
		prog_len++;
	endtask

	// lui then addi with the upper part rounded for the signed low part
	task automatic load_const(input reg_idx_t rd, input word_t v);
		logic [19:0] up;
		up = v[31:12] + {19'b0, v[11]};
		emit(enc_u(up, rd, opc_lui));
		emit(enc_i(v[11:0], rd, 3'b000, rd, opc_op_imm));
	endtask

	task automatic new_program();
		prog_len = 0;
		for (int i = 0; i < 256; i++) begin
			imem[i] = 32'h0000_0013; // addi x0, x0, 0
			dmem[i] = word_t'(i * 4) ^ 32'h5a5a_c3c3;
			m_dmem[i] = dmem[i];
		end
	endtask

	function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
			input word_t a, input word_t b);
		case (f3)
			3'b000: return alt ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return {31'b0, $signed(a) < $signed(b)};
			3'b011: return {31'b0, a < b};
			3'b100: return a ^ b;
			3'b101: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	// executes the instruction at m_pc and fills the expected retire fields
	task automatic model_step();
		word_t ins, a, b, imm_i, imm_s, imm_b, imm_u, imm_j, addr;
		logic [2:0] f3;
		logic cond;
		ins = imem[m_pc[9:2]];
		f3 = ins[14:12];
		a = m_regs[ins[19:15]];
		b = m_regs[ins[24:20]];
		imm_i = {{20{ins[31]}}, ins[31:20]};
		imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
		imm_u = {ins[31:12], 12'b0};
		imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
		exp_pc = m_pc;
		exp_rd = ins[11:7];
		exp_we = 1'b0;
		exp_wdata = '0;
		exp_dreq = 1'b0;
		exp_dwe = 1'b0;
		exp_daddr = '0;
		exp_dwdata = '0;
		m_next = m_pc + 32'd4;
		case (ins[6:0])
			opc_op: begin
				exp_wdata = alu_ref(f3, ins[30], a, b);
				exp_we = 1'b1;
			end
			opc_op_imm: begin
				exp_wdata = alu_ref(f3, f3 == 3'b101 && ins[30], a, imm_i);
				exp_we = 1'b1;
			end
			opc_lui: begin
				exp_wdata = imm_u;
				exp_we = 1'b1;
			end
			opc_auipc: begin
				exp_wdata = m_pc + imm_u;
				exp_we = 1'b1;
			end
			opc_jal: begin
				exp_wdata = m_pc + 32'd4;
				exp_we = 1'b1;
				m_next = m_pc + imm_j;
			end
			opc_jalr: begin
				exp_wdata = m_pc + 32'd4;
				exp_we = 1'b1;
				m_next = (a + imm_i) & ~32'h1;
			end
			opc_branch: begin
				case (f3)
					3'b000: cond = a == b;
					3'b001: cond = a != b;
					3'b100: cond = $signed(a) < $signed(b);
					3'b101: cond = $signed(a) >= $signed(b);
					3'b110: cond = a < b;
					default: cond = a >= b;
				endcase
				if (cond)
					m_next = m_pc + imm_b;
			end
			opc_load: begin
				addr = a + imm_i;
				if (f3 == 3'b010 && addr[1:0] == 2'b00) begin
					exp_dreq = 1'b1;
					exp_daddr = addr;
					exp_wdata = m_dmem[addr[9:2]];
					exp_we = 1'b1;
				end
			end
			opc_store: begin
				addr = a + imm_s;
				if (f3 == 3'b010 && addr[1:0] == 2'b00) begin
					exp_dreq = 1'b1;
					exp_dwe = 1'b1;
					exp_daddr = addr;
					exp_dwdata = b;
					m_dmem[addr[9:2]] = b;
				end
			end
			default: ;
		endcase
		if (exp_rd == 5'd0)
			exp_we = 1'b0;
		if (exp_we)
			m_regs[exp_rd] = exp_wdata;
		m_pc = m_next;
	endtask

	task automatic wait_retire();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!retire_valid) begin
			cycles++;
			if (cycles > retire_timeout)
				fail_msg("timeout waiting for retire_valid");
			@(negedge clk);
		end
	endtask

	// reset and expect the first fetch from reset_pc right after release
	task automatic start_core();
		int cycles;
		for (int i = 0; i < 32; i++)
			m_regs[i] = '0;
		m_pc = reset_pc;
		clk_i.apply_reset();
		dm_addr.delete();
		dm_wdata.delete();
		dm_we.delete();
		@(negedge clk);
		check_bit("imem_req", imem_req, 1'b0);
		check_bit("dmem_req", dmem_req, 1'b0);
		check_bit("retire_valid", retire_valid, 1'b0);
		cycles = 0;
		while (!imem_req) begin
			cycles++;
			if (cycles > fetch_timeout)
				fail_msg("timeout waiting for the first imem_req");
			@(negedge clk);
		end
		check_word("first fetch delay", word_t'(cycles), 32'd1);
		check_word("imem_addr", imem_addr, reset_pc);
	endtask

	task automatic run_to(input word_t end_pc);
		int n, last_cycle;
		n = 0;
		last_cycle = 0;
		start_core();
		while (m_pc != end_pc) begin
			if (n >= 100)
				fail_msg("program did not reach its end address");
			wait_retire();
			model_step();
			if (n > 0)
				check_word("retire spacing", word_t'(cycle_count - last_cycle), 32'd5);
			last_cycle = cycle_count;
			check_word("retire_pc", retire_pc, exp_pc);
			check_reg("retire_rd", retire_rd, exp_rd);
			check_bit("retire_we", retire_we, exp_we);
			if (exp_we)
				check_word("retire_wdata", retire_wdata, exp_wdata);
			if (exp_dreq) begin
				if (dm_addr.size() == 0)
					fail_msg("expected data memory request did not occur");
				check_word("dmem_addr", dm_addr.pop_front(), exp_daddr);
				check_bit("dmem_we", dm_we.pop_front(), exp_dwe);
				if (exp_dwe)
					check_word("dmem_wdata", dm_wdata.pop_front(), exp_dwdata);
				else
					void'(dm_wdata.pop_front());
			end else if (dm_addr.size() != 0) begin
				fail_msg("unexpected data memory request");
			end
			n++;
		end
	endtask

	task automatic test_reset_timing();
		word_t r;
		new_program();
		for (int i = 1; i < 7; i++) begin
			r = $random(seed);
			emit(enc_i(r[11:0], 5'(i), 3'b000, 5'(i), opc_op_imm));
		end
		run_to(word_t'(prog_len * 4));
	endtask

	task automatic test_alu();
		word_t a, b, r;
		new_program();
		a = $random(seed);
		b = $random(seed);
		load_const(1, a);
		load_const(2, b);
		for (int i = 0; i < 8; i++)
			emit(enc_r(7'b0000000, 2, 1, 3'(i), 5'(3 + i)));
		emit(enc_r(7'b0100000, 2, 1, 3'b000, 11)); // sub
		emit(enc_r(7'b0100000, 2, 1, 3'b101, 12)); // sra
		foreach (imem[i]) begin
			if (i < 8 && i != 1 && i != 5) begin
				r = $random(seed);
				emit(enc_i(r[11:0], 1, 3'(i), 5'(13 + i), opc_op_imm));
			end
		end
		r = $random(seed);
		emit(enc_i({7'b0000000, r[4:0]}, 1, 3'b001, 21, opc_op_imm));
		emit(enc_i({7'b0000000, r[9:5]}, 2, 3'b101, 22, opc_op_imm));
		emit(enc_i({7'b0100000, r[14:10]}, 1, 3'b101, 23, opc_op_imm));
		run_to(word_t'(prog_len * 4));
	endtask

	task automatic test_upper_and_x0();
		word_t r;
		new_program();
		r = $random(seed);
		emit(enc_i(12'd0, 0, 3'b000, 0, opc_op_imm)); // keeps auipc pc nonzero
		emit(enc_u(r[19:0], 5, opc_lui));
		emit(enc_u(r[31:12], 6, opc_auipc));
		emit(enc_u(r[27:8], 0, opc_lui)); // x0 write dropped
		emit(enc_i(12'h123, 0, 3'b000, 0, opc_op_imm));
		emit(enc_r(7'b0000000, 0, 0, 3'b000, 7));
		run_to(word_t'(prog_len * 4));
	endtask

	task automatic test_branches_jumps();
		word_t a, target, end_pc;
		logic [2:0] kinds [6];
		int pos;
		kinds = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
		new_program();
		a = $random(seed);
		load_const(1, a);
		load_const(2, a ^ 32'h8000_0001); // differs in sign and magnitude
		load_const(3, a);
		foreach (kinds[k]) begin
			emit(enc_b(13'd8, 2, 1, kinds[k]));
			emit(enc_i(12'd1, 10, 3'b000, 10, opc_op_imm));
			emit(enc_b(13'd8, 1, 2, kinds[k]));
			emit(enc_i(12'd1, 10, 3'b000, 10, opc_op_imm));
			emit(enc_b(13'd8, 3, 1, kinds[k]));
			emit(enc_i(12'd1, 10, 3'b000, 10, opc_op_imm));
		end
		emit(enc_j(21'd12, 11));
		emit(enc_i(12'd1, 10, 3'b000, 10, opc_op_imm));
		emit(enc_i(12'd1, 10, 3'b000, 10, opc_op_imm));
		pos = prog_len;
		target = word_t'((pos + 4) * 4); // nop past the skipped addi
		end_pc = target + 32'd4;
		load_const(13, target + 32'd1); // bit 0 must be cleared by jalr
		emit(enc_i(12'd0, 13, 3'b000, 12, opc_jalr));
		emit(enc_i(12'd1, 10, 3'b000, 10, opc_op_imm));
		run_to(end_pc);
	endtask

	task automatic test_load_store();
		word_t r, base;
		new_program();
		r = $random(seed);
		base = 32'h0000_0100 | {24'b0, r[5:0], 2'b00};
		load_const(1, base);
		load_const(2, $random(seed));
		emit(enc_s(12'd8, 2, 1, 3'b010));
		emit(enc_i(12'd8, 1, 3'b010, 3, opc_load));
		emit(enc_i(12'd12, 1, 3'b010, 4, opc_load));
		emit(enc_s(12'd5, 2, 1, 3'b010)); // misaligned sw
		emit(enc_i(12'd8, 1, 3'b000, 5, opc_load)); // lb
		emit(enc_i(12'd2, 1, 3'b010, 7, opc_load));
		emit(enc_r(7'b0000000, 0, 3, 3'b000, 6));
		run_to(word_t'(prog_len * 4));
	endtask

	initial begin
		seed = 32'h0ae5_d8e3;
		cycle_count = 0;
		imem_rdata = '0;
		dmem_rdata = '0;
		test_reset_timing();
		test_alu();
		test_upper_and_x0();
		test_branches_jumps();
		test_load_store();
		$display("Testbench passed");
		$finish;
	end

endmodule

// File: testbench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
	output logic clk,
	output logic rst
);

	localparam int half_period = 20; // 40 ns clock
	localparam int reset_cycles = 10;

	initial begin
		clk = 1'b0;
		rst = 1'b1;
	end

	always #half_period clk = ~clk;

	// holds rst for ten rising edges and releases it on an edge
	task automatic apply_reset();
		rst <= 1'b1;
		repeat (reset_cycles) @(posedge clk);
		rst <= 1'b0;
	endtask

endmodule

// File: logic/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top import rv_core_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	output logic     imem_req,
	output word_t    imem_addr,
	input  word_t    imem_rdata,
	output logic     dmem_req,
	output logic     dmem_we,
	output word_t    dmem_addr,
	output word_t    dmem_wdata,
	input  word_t    dmem_rdata,
	output logic     retire_valid,
	output word_t    retire_pc,
	output reg_idx_t retire_rd,
	output logic     retire_we,
	output word_t    retire_wdata
);

	word_t instr, imm, pc;
	word_t rs1_value, rs2_value;
	word_t alu_result, next_pc;
	opclass_e opclass;
	alu_op_e alu_op;
	branch_op_e branch_op;
	wb_sel_e wb_sel;
	reg_idx_t rd, rs1, rs2;
	logic decode_en, execute_en, wb_en;

	cycle_sequencer sequencer_i (
		.clk(clk),
		.rst(rst),
		.imem_req(imem_req),
		.imem_addr(imem_addr),
		.imem_rdata(imem_rdata),
		.instr(instr),
		.opclass(opclass),
		.rs2_value(rs2_value),
		.alu_result(alu_result),
		.next_pc(next_pc),
		.dmem_req(dmem_req),
		.dmem_we(dmem_we),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.decode_en(decode_en),
		.execute_en(execute_en),
		.wb_en(wb_en),
		.pc(pc),
		.retire_valid(retire_valid),
		.retire_pc(retire_pc)
	);

	instr_decoder decoder_i (
		.clk(clk),
		.rst(rst),
		.decode_en(decode_en),
		.instr(instr),
		.opclass(opclass),
		.alu_op(alu_op),
		.branch_op(branch_op),
		.wb_sel(wb_sel),
		.rd(rd),
		.rs1(rs1),
		.rs2(rs2),
		.imm(imm)
	);

	integer_alu alu_i (
		.clk(clk),
		.rst(rst),
		.execute_en(execute_en),
		.opclass(opclass),
		.alu_op(alu_op),
		.branch_op(branch_op),
		.imm(imm),
		.rs1_value(rs1_value),
		.rs2_value(rs2_value),
		.pc(pc),
		.alu_result(alu_result),
		.next_pc(next_pc)
	);

	writeback_regfile regfile_i (
		.clk(clk),
		.rst(rst),
		.wb_en(wb_en),
		.wb_sel(wb_sel),
		.rd(rd),
		.rs1(rs1),
		.rs2(rs2),
		.alu_result(alu_result),
		.dmem_rdata(dmem_rdata),
		.pc(pc),
		.rs1_value(rs1_value),
		.rs2_value(rs2_value),
		.retire_rd(retire_rd),
		.retire_wdata(retire_wdata),
		.retire_we(retire_we)
	);

endmodule

// File: logic/cycle_sequencer.sv
`timescale 1ns/1ps

module cycle_sequencer import rv_core_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	output logic     imem_req,
	output word_t    imem_addr,
	input  word_t    imem_rdata,
	output word_t    instr,
	input  opclass_e opclass,
	input  word_t    rs2_value,
	input  word_t    alu_result,
	input  word_t    next_pc,
	output logic     dmem_req,
	output logic     dmem_we,
	output word_t    dmem_addr,
	output word_t    dmem_wdata,
	output logic     decode_en,
	output logic     execute_en,
	output logic     wb_en,
	output word_t    pc,
	output logic     retire_valid,
	output word_t    retire_pc
);

	state_e state, state_nxt;
	logic mem_op;

	always_comb begin
		case (state)
			st_fetch: state_nxt = st_decode;
			st_decode: state_nxt = st_execute;
			st_execute: state_nxt = st_memory;
			st_memory: state_nxt = st_writeback;
			st_writeback: state_nxt = st_fetch;
			default: state_nxt = st_writeback; // resync through a fetch
		endcase
	end

	// Reset parks the FSM in writeback with all strobes low, so the
	// first edge after reset moves into fetch with imem_req raised.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= st_writeback;
			imem_req <= 1'b0;
			decode_en <= 1'b0;
			execute_en <= 1'b0;
			wb_en <= 1'b0;
			pc <= reset_pc;
		end else begin
			state <= state_nxt;
			imem_req <= (state_nxt == st_fetch);
			decode_en <= (state_nxt == st_decode);
			execute_en <= (state_nxt == st_execute);
			wb_en <= (state_nxt == st_writeback);
			if (wb_en)
				pc <= next_pc; // real writeback only
		end
	end

	assign imem_addr = pc;
	// decoder samples the fetched word in the decode cycle
	assign instr = imem_rdata;

	assign mem_op = (opclass == op_load || opclass == op_store) && (alu_result[1:0] == 2'b00);

	assign dmem_req = (state == st_memory) && mem_op;
	assign dmem_we = dmem_req && (opclass == op_store);
	assign dmem_addr = alu_result;
	assign dmem_wdata = rs2_value;

	assign retire_valid = wb_en;
	assign retire_pc = pc;

endmodule

// File: logic/writeback_regfile.sv
`timescale 1ns/1ps

module writeback_regfile import rv_core_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     wb_en,
	input  wb_sel_e  wb_sel,
	input  reg_idx_t rd,
	input  reg_idx_t rs1,
	input  reg_idx_t rs2,
	input  word_t    alu_result,
	input  word_t    dmem_rdata,
	input  word_t    pc,
	output word_t    rs1_value,
	output word_t    rs2_value,
	output reg_idx_t retire_rd,
	output word_t    retire_wdata,
	output logic     retire_we
);

	word_t regs [32];
	word_t wb_data;
	logic misaligned;

	assign rs1_value = regs[rs1];
	assign rs2_value = regs[rs2];

	// a load whose address is not word aligned got no data
	assign misaligned = (wb_sel == wb_mem) && (alu_result[1:0] != 2'b00);

	always_comb begin
		case (wb_sel)
			wb_alu: wb_data = alu_result;
			wb_mem: wb_data = dmem_rdata;
			wb_link: wb_data = pc + instr_len;
			default: wb_data = '0;
		endcase
	end

	assign retire_we = (rd != 5'd0) && (wb_sel != wb_none) && !misaligned;
	assign retire_rd = rd;
	assign retire_wdata = wb_data;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wb_en && retire_we) begin
			regs[rd] <= wb_data; // x0 never written
		end
	end

endmodule

// File: logic/integer_alu.sv
`timescale 1ns/1ps

module integer_alu import rv_core_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       execute_en,
	input  opclass_e   opclass,
	input  alu_op_e    alu_op,
	input  branch_op_e branch_op,
	input  word_t      imm,
	input  word_t      rs1_value,
	input  word_t      rs2_value,
	input  word_t      pc,
	output word_t      alu_result,
	output word_t      next_pc
);

	word_t op_b;
	word_t fn_out;
	word_t seq_pc;
	logic [4:0] shamt;
	logic taken;

	// register form uses rs2, everything else the immediate
	assign op_b = (opclass == op_alu_reg) ? rs2_value : imm;
	assign shamt = op_b[4:0];
	assign seq_pc = pc + instr_len;

	always_comb begin
		case (alu_op)
			alu_add: fn_out = rs1_value + op_b;
			alu_sub: fn_out = rs1_value - op_b;
			alu_sll: fn_out = rs1_value << shamt;
			alu_slt: fn_out = {31'b0, $signed(rs1_value) < $signed(op_b)};
			alu_sltu: fn_out = {31'b0, rs1_value < op_b};
			alu_xor: fn_out = rs1_value ^ op_b;
			alu_srl: fn_out = rs1_value >> shamt;
			alu_sra: fn_out = $signed(rs1_value) >>> shamt;
			alu_or: fn_out = rs1_value | op_b;
			alu_and: fn_out = rs1_value & op_b;
			default: fn_out = '0;
		endcase
	end

	always_comb begin
		case (branch_op)
			br_eq: taken = rs1_value == rs2_value;
			br_ne: taken = rs1_value != rs2_value;
			br_lt: taken = $signed(rs1_value) < $signed(rs2_value);
			br_ge: taken = $signed(rs1_value) >= $signed(rs2_value);
			br_ltu: taken = rs1_value < rs2_value;
			br_geu: taken = rs1_value >= rs2_value;
			default: taken = 1'b0;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			alu_result <= '0;
			next_pc <= reset_pc;
		end else if (execute_en) begin
			case (opclass)
				op_lui: alu_result <= imm;
				op_auipc: alu_result <= pc + imm;
				default: alu_result <= fn_out; // also the lw/sw address
			endcase

			case (opclass)
				op_branch: next_pc <= taken ? pc + imm : seq_pc;
				op_jal: next_pc <= pc + imm;
				op_jalr: next_pc <= {fn_out[31:1], 1'b0};
				default: next_pc <= seq_pc; // misaligned lw/sw falls through here too
			endcase
		end
	end

endmodule

// File: logic/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder import rv_core_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       decode_en,
	input  word_t      instr,
	output opclass_e   opclass,
	output alu_op_e    alu_op,
	output branch_op_e branch_op,
	output wb_sel_e    wb_sel,
	output reg_idx_t   rd,
	output reg_idx_t   rs1,
	output reg_idx_t   rs2,
	output word_t      imm
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t imm_i, imm_s, imm_b, imm_j, imm_u;
	word_t imm_nxt;
	opclass_e cls;
	alu_op_e aop;
	branch_op_e bop;
	wb_sel_e wsel;

	function automatic alu_op_e alu_map(input logic [2:0] f3, input logic alt);
		alu_op_e op;
		case (f3)
			3'b000: op = alt ? alu_sub : alu_add;
			3'b001: op = alu_sll;
			3'b010: op = alu_slt;
			3'b011: op = alu_sltu;
			3'b100: op = alu_xor;
			3'b101: op = alt ? alu_sra : alu_srl;
			3'b110: op = alu_or;
			default: op = alu_and;
		endcase
		return op;
	endfunction

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};

	always_comb begin
		cls = op_illegal;
		aop = alu_add; // address and target adds
		bop = br_eq;
		imm_nxt = '0;
		case (opcode)
			opc_op: begin
				if (funct7 == 7'b0000000 ||
				    (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
					cls = op_alu_reg;
					aop = alu_map(funct3, funct7[5]);
				end
			end
			opc_op_imm: begin
				imm_nxt = imm_i;
				cls = op_alu_imm;
				aop = alu_map(funct3, funct3 == 3'b101 && funct7[5]);
				if (funct3 == 3'b001 && funct7 != 7'b0000000)
					cls = op_illegal;
				if (funct3 == 3'b101 && funct7 != 7'b0000000 && funct7 != 7'b0100000)
					cls = op_illegal;
			end
			opc_load: begin
				imm_nxt = imm_i;
				if (funct3 == 3'b010) cls = op_load; // lw only
			end
			opc_store: begin
				imm_nxt = imm_s;
				if (funct3 == 3'b010) cls = op_store; // sw only
			end
			opc_branch: begin
				imm_nxt = imm_b;
				cls = op_branch;
				case (funct3)
					3'b000: bop = br_eq;
					3'b001: bop = br_ne;
					3'b100: bop = br_lt;
					3'b101: bop = br_ge;
					3'b110: bop = br_ltu;
					3'b111: bop = br_geu;
					default: cls = op_illegal;
				endcase
			end
			opc_jal: begin
				imm_nxt = imm_j;
				cls = op_jal;
			end
			opc_jalr: begin
				imm_nxt = imm_i;
				if (funct3 == 3'b000) cls = op_jalr;
			end
			opc_lui: begin
				imm_nxt = imm_u;
				cls = op_lui;
			end
			opc_auipc: begin
				imm_nxt = imm_u;
				cls = op_auipc;
			end
			default: cls = op_illegal;
		endcase
	end

	always_comb begin
		case (cls)
			op_alu_reg, op_alu_imm, op_lui, op_auipc: wsel = wb_alu;
			op_load: wsel = wb_mem;
			op_jal, op_jalr: wsel = wb_link;
			default: wsel = wb_none; // branches, stores, no-ops
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			opclass <= op_illegal;
			alu_op <= alu_add;
			branch_op <= br_eq;
			wb_sel <= wb_none;
			rd <= '0;
			rs1 <= '0;
			rs2 <= '0;
			imm <= '0;
		end else if (decode_en) begin
			opclass <= cls;
			alu_op <= aop;
			branch_op <= bop;
			wb_sel <= wsel;
			rd <= instr[11:7];
			rs1 <= instr[19:15];
			rs2 <= instr[24:20];
			imm <= imm_nxt;
		end
	end

endmodule

// File: logic/rv_core_pkg.sv
package rv_core_pkg;

	localparam int xlen = 32;

	typedef logic [xlen-1:0] word_t;
	typedef logic [4:0] reg_idx_t;

	// decoded instruction class
	typedef enum logic [3:0] {
		op_alu_reg,
		op_alu_imm,
		op_load,
		op_store,
		op_branch,
		op_jal,
		op_jalr,
		op_lui,
		op_auipc,
		op_illegal
	} opclass_e;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and
	} alu_op_e;

	typedef enum logic [2:0] {
		br_eq,
		br_ne,
		br_lt,
		br_ge,
		br_ltu,
		br_geu
	} branch_op_e;

	typedef enum logic [1:0] {
		wb_alu,
		wb_mem,
		wb_link, // pc + 4
		wb_none
	} wb_sel_e;

	typedef enum logic [2:0] {
		st_fetch,
		st_decode,
		st_execute,
		st_memory,
		st_writeback
	} state_e;

	// rv32i base opcodes
	localparam logic [6:0] opc_op     = 7'b0110011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;
	localparam logic [6:0] opc_load   = 7'b0000011;
	localparam logic [6:0] opc_store  = 7'b0100011;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_jal    = 7'b1101111;
	localparam logic [6:0] opc_jalr   = 7'b1100111;
	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_auipc  = 7'b0010111;

	localparam word_t reset_pc  = 32'h0000_0000;
	localparam word_t instr_len = 32'd4;

endpackage
